// File: list.f
+incdir+common
common/eth_rx_pkg.sv
logic/rx_packet_fifo.sv
logic/rx_length_fifo.sv
rx_buffer/rx_frame_writer.sv
rx_buffer/apb_rx_regs.sv
rx_buffer/apb_eth_rx_buffer.sv
sim/apb_eth_rx_buffer_checker.sv
sim/apb_eth_rx_buffer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the APB Ethernet rx buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=apb_eth_rx_buffer_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module apb_eth_rx_buffer_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0

// File: sim/apb_eth_rx_buffer_tb.sv
`timescale 1ns/1ps
`include "eth_rx_defines.svh"

module apb_eth_rx_buffer_tb;

	localparam int CLK_NS = 100;
	// Upper bound on frame words streamed plus words read back over all tests
	localparam int WORD_BOUND = 6000;

	logic                    apb;
	logic                    rst_n;
	logic                    link_up;
	logic                    rx_frame_ready;
	eth_rx_pkg::apb_req_t    apb_req;
	eth_rx_pkg::apb_rsp_t    apb_rsp;
	eth_rx_pkg::eth_rx_bus_t eth_rx;

	logic [31:0] lcg_state;
	int          errors;
	int          test_errors;
	int          tests_run;
	bit          run_done;

	apb_eth_rx_buffer dut (
		.apb(apb), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.eth_rx(eth_rx), .link_up(link_up), .rx_frame_ready(rx_frame_ready)
	);

	bind apb_eth_rx_buffer apb_eth_rx_buffer_checker u_checker (
		.apb(apb), .rst_n(rst_n), .apb_rsp(apb_rsp),
		.link_up(link_up), .rx_frame_ready(rx_frame_ready)
	);

	always #(CLK_NS / 2) apb = ~apb;

	//////////////////////////////////////////////////////////////////////////
	// Stimulus and reference model

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = lcg_next();
		return lo + int'(r[31:16]) % (hi - lo + 1);
	endfunction

	// Byte k of a frame mixes in every bit of the index
	function automatic logic [7:0] frame_byte(input logic [31:0] seed, input int k);
		logic [31:0] v;
		v = seed ^ (32'(k) * 32'h9e3779b1);
		return v[23:16] ^ v[7:0];
	endfunction

	// Expected readback has the first byte in bits 7:0 and zeros past the end
	function automatic eth_rx_pkg::rx_word_t frame_word(input logic [31:0] seed,
			input int len, input int idx);
		eth_rx_pkg::rx_word_t w;
		w = '0;
		for (int j = 0; j < 4; j++) begin
			if (idx * 4 + j < len) begin
				w[8 * j +: 8] = frame_byte(seed, idx * 4 + j);
			end
		end
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic check_word(input string name, input eth_rx_pkg::rx_word_t expected,
			input eth_rx_pkg::rx_word_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			count_error();
		end
	endtask

	task automatic check_len(input string name, input eth_rx_pkg::frame_len_t expected,
			input eth_rx_pkg::frame_len_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			count_error();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
			count_error();
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %s: passed", name);
		end else begin
			$display("Test %s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Bus drivers are entered and left on a falling edge

	// Setup, access, then one more access cycle carrying ready
	task automatic apb_xfer(input logic write, input eth_rx_pkg::reg_addr_t addr,
			input eth_rx_pkg::rx_word_t wdata, output eth_rx_pkg::rx_word_t rdata,
			output logic slverr);
		int access_cycles;
		apb_req.sel    = 1'b1;
		apb_req.enable = 1'b0;
		apb_req.write  = write;
		apb_req.addr   = addr;
		apb_req.wdata  = wdata;
		@(negedge apb);
		apb_req.enable = 1'b1;
		access_cycles  = 0;
		do begin
			@(negedge apb);
			access_cycles++;
		end while (!apb_rsp.ready && access_cycles < 8);
		if (access_cycles != 1) begin
			$display("APB transfer at %h did not get ready after the fixed wait", addr);
			count_error();
		end
		rdata  = apb_rsp.rdata;
		slverr = apb_rsp.slverr;
		// Hold through the ready cycle so a pop write is seen
		@(negedge apb);
		apb_req = '0;
	endtask

	task automatic apb_read(input eth_rx_pkg::reg_addr_t addr,
			output eth_rx_pkg::rx_word_t rdata, output logic slverr);
		apb_xfer(1'b0, addr, '0, rdata, slverr);
	endtask

	task automatic apb_write(input eth_rx_pkg::reg_addr_t addr,
			input eth_rx_pkg::rx_word_t wdata, output logic slverr);
		eth_rx_pkg::rx_word_t unused;
		apb_xfer(1'b1, addr, wdata, unused, slverr);
	endtask

	// Start, data words, then commit on its own cycle
	task automatic send_frame(input logic [31:0] seed, input int len);
		int nb;
		eth_rx.start = 1'b1;
		@(negedge apb);
		eth_rx.start = 1'b0;
		for (int i = 0; i < (len + 3) / 4; i++) begin
			nb = (len - 4 * i > 4) ? 4 : len - 4 * i;
			eth_rx.data_valid  = 1'b1;
			eth_rx.bytes_valid = 3'(nb);
			eth_rx.data        = '0;
			for (int j = 0; j < nb; j++) begin
				eth_rx.data[31 - 8 * j -: 8] = frame_byte(seed, 4 * i + j);
			end
			@(negedge apb);
		end
		eth_rx        = '0;
		eth_rx.commit = 1'b1;
		@(negedge apb);
		eth_rx.commit = 1'b0;
	endtask

	task automatic wait_level(input string name, input logic level);
		int cycles;
		cycles = 0;
		while (rx_frame_ready !== level && cycles < 16) begin
			@(negedge apb);
			cycles++;
		end
		if (rx_frame_ready !== level) begin
			$display("%s: rx_frame_ready never went to %b", name, level);
			count_error();
		end
	endtask

	// Length, every word, then release the frame
	task automatic read_frame(input string name, input logic [31:0] seed, input int len);
		eth_rx_pkg::rx_word_t data;
		logic err;
		apb_read(`REG_RX_LEN, data, err);
		check_len({name, " length"}, eth_rx_pkg::frame_len_t'(len), data[10:0]);
		check_flag({name, " length slverr"}, 1'b0, err);
		for (int i = 0; i < (len + 3) / 4; i++) begin
			apb_read(eth_rx_pkg::reg_addr_t'(i * 4), data, err);
			check_word($sformatf("%s word %0d", name, i), frame_word(seed, len, i), data);
		end
		apb_write(`REG_RX_POP, '0, err);
		check_flag({name, " pop slverr"}, 1'b0, err);
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0]          seeds [4];
		int                   lens [4];
		eth_rx_pkg::rx_word_t data;
		logic                 err;
		apb = 1'b0;
		rst_n = 1'b0;
		link_up = 1'b0;
		apb_req = '0;
		eth_rx = '0;
		lcg_state = 32'hd412ee9b;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		run_done = 1'b0;
		repeat (3) @(negedge apb);
		rst_n = 1'b1;
		link_up = 1'b1;
		@(negedge apb);

		// Idle status after reset
		check_flag("reset frame ready", 1'b0, rx_frame_ready);
		apb_read(`REG_RX_LEN, data, err);
		check_word("reset length", '0, data);
		check_flag("reset slverr", 1'b0, err);
		finish_test("reset");

		// One frame of any legal size
		seeds[0] = lcg_next();
		lens[0] = rand_range(1, `RX_MAX_FRAME);
		send_frame(seeds[0], lens[0]);
		wait_level("single", 1'b1);
		read_frame("single", seeds[0], lens[0]);
		wait_level("single", 1'b0);
		finish_test("single");

		// Queue of frames read back in arrival order
		for (int f = 0; f < 4; f++) begin
			seeds[f] = lcg_next();
			lens[f] = rand_range(1, 600);
			send_frame(seeds[f], lens[f]);
		end
		repeat (2) @(negedge apb);
		for (int f = 0; f < 4; f++) begin
			wait_level("queue", 1'b1);
			read_frame($sformatf("queue frame %0d", f), seeds[f], lens[f]);
		end
		wait_level("queue", 1'b0);
		finish_test("queue");

		// Bad accesses leave the stored frame alone
		seeds[0] = lcg_next();
		lens[0] = rand_range(1, `RX_MAX_FRAME);
		send_frame(seeds[0], lens[0]);
		wait_level("errors", 1'b1);
		apb_read(`REG_RX_POP, data, err);
		check_flag("pop read slverr", 1'b1, err);
		apb_write(`REG_RX_LEN, 32'h0000_0001, err);
		check_flag("length write slverr", 1'b1, err);
		apb_write(12'h000, 32'hffff_ffff, err);
		check_flag("buffer write slverr", 1'b1, err);
		read_frame("errors", seeds[0], lens[0]);
		wait_level("errors", 1'b0);
		finish_test("errors");

		// Oversize and empty frames vanish
		send_frame(lcg_next(), `RX_MAX_FRAME + 100);
		send_frame(lcg_next(), 0);
		repeat (4) @(negedge apb);
		check_flag("oversize and empty dropped", 1'b0, rx_frame_ready);
		// Two full frames leave less than the admit threshold
		seeds[0] = lcg_next();
		seeds[1] = lcg_next();
		send_frame(seeds[0], `RX_MAX_FRAME);
		send_frame(seeds[1], `RX_MAX_FRAME);
		send_frame(lcg_next(), rand_range(1, 600));
		repeat (2) @(negedge apb);
		read_frame("fill frame 0", seeds[0], `RX_MAX_FRAME);
		read_frame("fill frame 1", seeds[1], `RX_MAX_FRAME);
		wait_level("no space drop", 1'b0);
		seeds[2] = lcg_next();
		lens[2] = rand_range(1, 600);
		send_frame(seeds[2], lens[2]);
		wait_level("after drops", 1'b1);
		read_frame("after drops", seeds[2], lens[2]);
		wait_level("after drops", 1'b0);
		finish_test("drops");

		// Link loss flushes stored frames
		send_frame(lcg_next(), rand_range(1, 600));
		send_frame(lcg_next(), rand_range(1, 600));
		wait_level("link", 1'b1);
		link_up = 1'b0;
		repeat (2) @(negedge apb);
		check_flag("link down frame ready", 1'b0, rx_frame_ready);
		link_up = 1'b1;
		@(negedge apb);
		seeds[3] = lcg_next();
		lens[3] = rand_range(1, 600);
		send_frame(seeds[3], lens[3]);
		wait_level("link", 1'b1);
		read_frame("after link up", seeds[3], lens[3]);
		wait_level("link", 1'b0);
		finish_test("link");

		run_done = 1'b1;
		$display("Tests run: %0d, failed checks: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// At most three cycles per frame word streamed or read back
	// Slack covers starts, commits, length reads and pops
	initial begin
		#((WORD_BOUND * 3 + 2000) * CLK_NS);
		run_done = 1'b1;
		$display("Watchdog expired before the tests completed");
		$display("Simulation failed");
		$finish;
	end

	// A stop from an assertion ends the run early
	final begin
		if (!run_done) begin
			$display("Simulation failed");
		end
	end

endmodule

// File: sim/apb_eth_rx_buffer_checker.sv
`timescale 1ns/1ps

module apb_eth_rx_buffer_checker (
	input logic                 apb,
	input logic                 rst_n,
	input eth_rx_pkg::apb_rsp_t apb_rsp,
	input logic                 link_up,
	input logic                 rx_frame_ready
);

	//////////////////////////////////////////////////////////////////////////
	// APB response

	// Ready is a single cycle pulse
	ready_single: assert property (@(posedge apb) disable iff (!rst_n)
		apb_rsp.ready |=> !apb_rsp.ready)
		else $error("APB ready high on two consecutive cycles");

	// Error only alongside ready
	slverr_with_ready: assert property (@(posedge apb) disable iff (!rst_n)
		apb_rsp.slverr |-> apb_rsp.ready)
		else $error("APB slverr without ready");

	//////////////////////////////////////////////////////////////////////////
	// Status level

	// Link loss empties the length FIFO by the next cycle
	link_flush: assert property (@(posedge apb) disable iff (!rst_n)
		!link_up |=> !rx_frame_ready)
		else $error("rx_frame_ready high after link_up was low");

endmodule

// File: rx_buffer/apb_eth_rx_buffer.sv
`timescale 1ns/1ps

module apb_eth_rx_buffer (
	input  logic                     apb,
	input  logic                     rst_n,
	input  eth_rx_pkg::apb_req_t     apb_req,
	output eth_rx_pkg::apb_rsp_t     apb_rsp,
	input  eth_rx_pkg::eth_rx_bus_t  eth_rx,
	input  logic                     link_up,
	output logic                     rx_frame_ready
);

	// Push side
	logic                    wr_en;
	eth_rx_pkg::rx_word_t    wr_data;
	logic                    wr_commit;
	logic                    wr_rollback;
	eth_rx_pkg::fifo_level_t free_words;
	logic                    len_push;
	eth_rx_pkg::frame_len_t  len_data;
	logic                    len_full;

	// Read side
	logic                    rd_en;
	eth_rx_pkg::fifo_level_t rd_offset;
	eth_rx_pkg::rx_word_t    rd_data;
	logic                    pop_packet;
	eth_rx_pkg::fifo_level_t pop_words;
	logic                    len_pop;
	eth_rx_pkg::frame_len_t  len_head;
	logic                    len_empty;

	// Link down flushes stored frames
	logic                    fifo_clear;

	assign fifo_clear = !link_up;

	rx_frame_writer u_writer (
		.apb(apb), .rst_n(rst_n), .link_up(link_up), .eth_rx(eth_rx),
		.free_words(free_words), .len_full(len_full),
		.wr_en(wr_en), .wr_data(wr_data), .wr_commit(wr_commit),
		.wr_rollback(wr_rollback), .len_push(len_push), .len_data(len_data)
	);

	rx_packet_fifo u_packet_fifo (
		.apb(apb), .rst_n(rst_n), .clear(fifo_clear),
		.wr_en(wr_en), .wr_data(wr_data), .wr_commit(wr_commit),
		.wr_rollback(wr_rollback), .free_words(free_words),
		.rd_en(rd_en), .rd_offset(rd_offset), .rd_data(rd_data),
		.pop_packet(pop_packet), .pop_words(pop_words)
	);

	rx_length_fifo u_length_fifo (
		.apb(apb), .rst_n(rst_n), .clear(fifo_clear),
		.push(len_push), .din(len_data), .full(len_full),
		.pop(len_pop), .dout(len_head), .empty(len_empty)
	);

	apb_rx_regs u_regs (
		.apb(apb), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.rd_en(rd_en), .rd_offset(rd_offset), .rd_data(rd_data),
		.len_head(len_head), .len_empty(len_empty), .len_pop(len_pop),
		.pop_packet(pop_packet), .pop_words(pop_words),
		.rx_frame_ready(rx_frame_ready)
	);

endmodule

// File: rx_buffer/apb_rx_regs.sv
`timescale 1ns/1ps
`include "eth_rx_defines.svh"

module apb_rx_regs (
	input  logic                     apb,
	input  logic                     rst_n,

	// APB completer
	input  eth_rx_pkg::apb_req_t     apb_req,
	output eth_rx_pkg::apb_rsp_t     apb_rsp,

	// Packet FIFO read side
	output logic                     rd_en,
	output eth_rx_pkg::fifo_level_t  rd_offset,
	input  eth_rx_pkg::rx_word_t     rd_data,

	// Length FIFO head
	input  eth_rx_pkg::frame_len_t   len_head,
	input  logic                     len_empty,
	output logic                     len_pop,

	// Frame release
	output logic                     pop_packet,
	output eth_rx_pkg::fifo_level_t  pop_words,

	// Status level
	output logic                     rx_frame_ready
);

	logic                    ready_q;
	logic                    ready_next;
	logic                    pop_hit;
	eth_rx_pkg::rx_word_t    rd_swapped;
	eth_rx_pkg::fifo_level_t head_words;

	//////////////////////////////////////////////////////////////////////////
	// Access timing
	// First access cycle fetches and the second one answers

	assign ready_next = apb_req.sel && apb_req.enable && !ready_q;

	// Frame words sit at offset 0, so the word address indexes the FIFO
	// Every access fetches, status registers simply ignore the word
	assign rd_en     = ready_next;
	assign rd_offset = eth_rx_pkg::fifo_level_t'(apb_req.addr[11:2]);

	// First frame byte goes to bits 7:0
	assign rd_swapped = {rd_data[7:0], rd_data[15:8], rd_data[23:16], rd_data[31:24]};

	// Bytes to words rounded up
	assign head_words = eth_rx_pkg::fifo_level_t'(len_head[10:2]) +
		eth_rx_pkg::fifo_level_t'(|len_head[1:0]);

	assign pop_hit = ready_q && apb_req.write && (apb_req.addr == `REG_RX_POP);

	assign len_pop        = pop_packet;
	assign rx_frame_ready = !len_empty;

	//////////////////////////////////////////////////////////////////////////
	// Readback and error decode during ready

	always_comb begin
		apb_rsp       = '0;
		apb_rsp.ready = ready_q;
		if (ready_q) begin
			if (!apb_req.write) begin
				if (apb_req.addr == `REG_RX_LEN) begin
					apb_rsp.rdata = eth_rx_pkg::rx_word_t'(len_head);
				end else if (apb_req.addr == `REG_RX_POP) begin
					// Pop register is write only
					apb_rsp.slverr = 1'b1;
				end else begin
					apb_rsp.rdata = rd_swapped;
				end
			end else if (apb_req.addr != `REG_RX_POP) begin
				// Buffer and length are read only
				apb_rsp.slverr = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Control registers

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			ready_q    <= 1'b0;
			pop_packet <= 1'b0;
		end else begin
			ready_q <= ready_next;
			// Pop with nothing stored is ignored
			pop_packet <= pop_hit && !len_empty;
		end
	end

	// Size latched with the pop request
	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			pop_words <= '0;
		end else if (pop_hit) begin
			pop_words <= head_words;
		end
	end

endmodule

// File: rx_buffer/rx_frame_writer.sv
`timescale 1ns/1ps
`include "eth_rx_defines.svh"

module rx_frame_writer (
	input  logic                     apb,
	input  logic                     rst_n,
	input  logic                     link_up,
	input  eth_rx_pkg::eth_rx_bus_t  eth_rx,
	input  eth_rx_pkg::fifo_level_t  free_words,
	input  logic                     len_full,
	output logic                     wr_en,
	output eth_rx_pkg::rx_word_t     wr_data,
	output logic                     wr_commit,
	output logic                     wr_rollback,
	output logic                     len_push,
	output eth_rx_pkg::frame_len_t   len_data
);

	eth_rx_pkg::writer_state_t state;
	eth_rx_pkg::frame_len_t    len_count;
	eth_rx_pkg::frame_len_t    next_len;
	logic                      overflow;
	logic                      admit;

	// Byte count including this cycle's word
	always_comb begin
		next_len = len_count;
		if (eth_rx.data_valid) begin
			next_len = len_count + eth_rx_pkg::frame_len_t'(eth_rx.bytes_valid);
		end
	end

	// Too long, or packet FIFO about to run out
	assign overflow = eth_rx.data_valid &&
		((next_len > eth_rx_pkg::frame_len_t'(`RX_MAX_FRAME)) ||
		(free_words < eth_rx_pkg::fifo_level_t'(2)));

	// Room for a full sized frame and one more length entry
	assign admit = (free_words >= eth_rx_pkg::fifo_level_t'(`RX_MIN_SPACE)) && !len_full;

	// Word register
	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			wr_data <= '0;
		end else if (eth_rx.data_valid) begin
			wr_data <= eth_rx.data;
		end
	end

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			state       <= eth_rx_pkg::WR_IDLE;
			len_count   <= '0;
			len_data    <= '0;
			wr_en       <= 1'b0;
			wr_commit   <= 1'b0;
			wr_rollback <= 1'b0;
			len_push    <= 1'b0;
		end else begin
			wr_en       <= 1'b0;
			wr_commit   <= 1'b0;
			wr_rollback <= 1'b0;
			len_push    <= 1'b0;
			if (!link_up) begin
				// FIFOs are cleared alongside so there is nothing to undo
				state     <= eth_rx_pkg::WR_IDLE;
				len_count <= '0;
			end else if (eth_rx.start) begin
				// Start carries no data and words follow
				len_count <= '0;
				// Frame cut short by a new start
				if (state == eth_rx_pkg::WR_RECEIVE) begin
					wr_rollback <= 1'b1;
				end
				state <= admit ? eth_rx_pkg::WR_RECEIVE : eth_rx_pkg::WR_DROP;
			end else if (state == eth_rx_pkg::WR_RECEIVE) begin
				if (overflow) begin
					wr_rollback <= 1'b1;
					state       <= eth_rx_pkg::WR_DROP;
				end else begin
					if (eth_rx.data_valid) begin
						wr_en     <= 1'b1;
						len_count <= next_len;
					end
					// Empty frames commit nothing visible and get no length entry
					if (eth_rx.commit) begin
						wr_commit <= 1'b1;
						len_push  <= (next_len != '0);
						len_data  <= next_len;
						state     <= eth_rx_pkg::WR_IDLE;
					end
				end
			end
		end
	end

endmodule

// File: logic/rx_length_fifo.sv
`timescale 1ns/1ps
`include "eth_rx_defines.svh"

module rx_length_fifo (
	input  logic                    apb,
	input  logic                    rst_n,
	input  logic                    clear,
	input  logic                    push,
	input  eth_rx_pkg::frame_len_t  din,
	output logic                    full,
	input  logic                    pop,
	output eth_rx_pkg::frame_len_t  dout,
	output logic                    empty
);

	localparam int LEN_DEPTH = 1 << `RX_LEN_DEPTH_BITS;

	eth_rx_pkg::frame_len_t mem [LEN_DEPTH];

	// Pointers with wrap bit
	logic [`RX_LEN_DEPTH_BITS:0] wr_ptr;
	logic [`RX_LEN_DEPTH_BITS:0] rd_ptr;
	logic [`RX_LEN_DEPTH_BITS:0] level;

	assign level = wr_ptr - rd_ptr;

	// Top bit of the level is only set when all entries are used
	assign full  = level[`RX_LEN_DEPTH_BITS];
	assign empty = (level == '0);

	// Head of queue is the oldest stored frame, zero when nothing waits
	assign dout = empty ? '0 : mem[rd_ptr[`RX_LEN_DEPTH_BITS-1:0]];

	always_ff @(posedge apb) begin
		if (push && !full) begin
			mem[wr_ptr[`RX_LEN_DEPTH_BITS-1:0]] <= din;
		end
	end

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// Overflow and underflow are ignored
			if (push && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

// File: logic/rx_packet_fifo.sv
`timescale 1ns/1ps
`include "eth_rx_defines.svh"

module rx_packet_fifo (
	input  logic                     apb,
	input  logic                     rst_n,
	input  logic                     clear,

	// Push side
	input  logic                     wr_en,
	input  eth_rx_pkg::rx_word_t     wr_data,
	input  logic                     wr_commit,
	input  logic                     wr_rollback,
	output eth_rx_pkg::fifo_level_t  free_words,

	// Read side
	input  logic                     rd_en,
	input  eth_rx_pkg::fifo_level_t  rd_offset,
	output eth_rx_pkg::rx_word_t     rd_data,
	input  logic                     pop_packet,
	input  eth_rx_pkg::fifo_level_t  pop_words
);

	localparam int DEPTH = 1 << `RX_FIFO_ADDR_BITS;

	//////////////////////////////////////////////////////////////////////////
	// Storage and pointers

	eth_rx_pkg::rx_word_t mem [DEPTH];

	// Pointers carry one wrap bit above the RAM index
	eth_rx_pkg::fifo_level_t wr_ptr_tent;
	eth_rx_pkg::fifo_level_t wr_ptr_commit;
	eth_rx_pkg::fifo_level_t rd_ptr;

	// Tentative pointer after this cycle's write
	eth_rx_pkg::fifo_level_t wr_ptr_next;

	// Absolute read location for offset reads
	eth_rx_pkg::fifo_level_t rd_addr;

	assign wr_ptr_next = wr_ptr_tent + eth_rx_pkg::fifo_level_t'(wr_en);
	assign rd_addr     = rd_ptr + rd_offset;

	// Space counts uncommitted words too, so a long frame sees the
	// room shrink while it is still being written
	assign free_words = eth_rx_pkg::fifo_level_t'(DEPTH) - (wr_ptr_tent - rd_ptr);

	//////////////////////////////////////////////////////////////////////////
	// RAM write port

	always_ff @(posedge apb) begin
		if (wr_en) begin
			mem[wr_ptr_tent[`RX_FIFO_ADDR_BITS-1:0]] <= wr_data;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// RAM read port with one cycle latency
	// Reads past committed data return stale words

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= mem[rd_addr[`RX_FIFO_ADDR_BITS-1:0]];
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Pointer control

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_tent   <= '0;
			wr_ptr_commit <= '0;
			rd_ptr        <= '0;
		end else if (clear) begin
			// Link down empties committed and uncommitted words alike
			wr_ptr_tent   <= '0;
			wr_ptr_commit <= '0;
			rd_ptr        <= '0;
		end else begin
			// Rollback discards the frame in progress
			if (wr_rollback) begin
				wr_ptr_tent <= wr_ptr_commit;
			end else begin
				wr_ptr_tent <= wr_ptr_next;
			end

			// Commit may land together with the last word
			if (wr_commit) begin
				wr_ptr_commit <= wr_ptr_next;
			end

			// Whole frame leaves at once
			if (pop_packet) begin
				rd_ptr <= rd_ptr + pop_words;
			end
		end
	end

endmodule

// File: common/eth_rx_pkg.sv
`include "eth_rx_defines.svh"

package eth_rx_pkg;

	//////////////////////////////////////////////////////////////////////////
	// Widths with a meaning

	// One stored frame word
	typedef logic [31:0] rx_word_t;

	// Frame length in bytes
	typedef logic [10:0] frame_len_t;

	// Word count, one extra bit so a full FIFO is representable
	typedef logic [`RX_FIFO_ADDR_BITS:0] fifo_level_t;

	// Byte address inside the APB window
	typedef logic [11:0] reg_addr_t;

	//////////////////////////////////////////////////////////////////////////
	// Buses

	// Receive word stream, first byte in data[31:24]
	typedef struct packed {
		logic       start;
		logic       data_valid;
		logic [2:0] bytes_valid;
		rx_word_t   data;
		logic       commit;
	} eth_rx_bus_t;

	// APB request from the requester
	typedef struct packed {
		logic      sel;
		logic      enable;
		logic      write;
		reg_addr_t addr;
		rx_word_t  wdata;
	} apb_req_t;

	// APB response, rdata and slverr only meaningful with ready
	typedef struct packed {
		logic     ready;
		rx_word_t rdata;
		logic     slverr;
	} apb_rsp_t;

	// Push side FSM
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_RECEIVE,
		WR_DROP
	} writer_state_t;

endpackage

// File: common/eth_rx_defines.svh
`ifndef ETH_RX_DEFINES_SVH
`define ETH_RX_DEFINES_SVH

//////////////////////////////////////////////////////////////////////////////
// Buffer sizing

// Packet FIFO depth in words, as log2
`define RX_FIFO_ADDR_BITS 10

// Length FIFO depth in frames, as log2
`define RX_LEN_DEPTH_BITS 5

// Largest accepted frame in bytes
`define RX_MAX_FRAME 1500

// Free words needed before a new frame is admitted
`define RX_MIN_SPACE 375

//////////////////////////////////////////////////////////////////////////////
// Register map, byte offsets in the 4 KB window
// Frame words start at offset 0

`define REG_RX_POP 12'hff8
`define REG_RX_LEN 12'hffc

`endif
